/* logic/rob_pkg.sv */
package rob_pkg;

    ////////////////////
    // basic types
    ////////////////////

    // smaller buffers use only the low bits of the slot index
    typedef logic [5:0] rob_idx_t;
    typedef logic [4:0] areg_t;

    typedef enum logic [1:0] {
        op_add = 2'd0,
        op_sub = 2'd1,
        op_xor = 2'd2,
        op_mul = 2'd3
    } op_e;

    ////////////////////
    // payloads
    ////////////////////

    // front end to dispatch
    typedef struct packed {
        op_e         op;
        areg_t       areg;
        logic [31:0] operand_a;
        logic [31:0] operand_b;
        logic [31:0] pc;
    } front_inst_t;

    // dispatch to one execution lane
    typedef struct packed {
        op_e         op;
        logic [31:0] operand_a;
        logic [31:0] operand_b;
        rob_idx_t    slot;
    } issue_t;

    // one lane of the common data bus
    typedef struct packed {
        logic        valid;
        rob_idx_t    slot;
        logic [31:0] data;
    } cdb_t;

    typedef struct packed {
        areg_t       areg;
        logic [31:0] pc;
    } rob_inst_entry_t;

    typedef struct packed {
        logic [31:0] data;
    } rob_data_entry_t;

    typedef struct packed {
        logic        valid;
        areg_t       areg;
        logic [31:0] data;
        logic [31:0] pc;
    } retire_t;

    // result of one lane operation
    function automatic logic [31:0] alu_result(
        input op_e         op,
        input logic [31:0] operand_a,
        input logic [31:0] operand_b
    );
        case (op)
            op_add:  return operand_a + operand_b;
            op_sub:  return operand_a - operand_b;
            op_xor:  return operand_a ^ operand_b;
            default: return operand_a * operand_b;
        endcase
    endfunction

endpackage

/* logic/banked_regfile.sv */
`timescale 1ns/10ps

module banked_regfile #(
    parameter type entry_t    = logic,
    parameter int  depth      = 16,
    parameter int  r_ports    = 2,
    parameter int  w_ports    = 2,
    parameter bit  need_reset = 1'b0
) (
    input  logic                              clk,
    input  logic                              rst_n_i,

    // read side, asynchronous
    input  rob_pkg::rob_idx_t [r_ports-1:0]   raddr_i,
    output entry_t            [r_ports-1:0]   rdata_o,

    // write side
    input  rob_pkg::rob_idx_t [w_ports-1:0]   waddr_i,
    input  logic              [w_ports-1:0]   we_i,
    input  entry_t            [w_ports-1:0]   wdata_i
);

    localparam int addr_w = $clog2(depth);

    entry_t mem_q [depth];

    ////////////////////
    // read ports
    ////////////////////

    always_comb begin
        for (int i = 0; i < r_ports; i++) begin
            // only the low bits address this depth
            rdata_o[i] = mem_q[raddr_i[i][addr_w-1:0]];
        end
    end

    ////////////////////
    // write ports
    ////////////////////

    // later ports overwrite earlier ones on an address clash
    always_ff @(posedge clk) begin
        if (need_reset && !rst_n_i) begin
            for (int j = 0; j < depth; j++) begin
                mem_q[j] <= '0;
            end
        end else begin
            for (int i = 0; i < w_ports; i++) begin
                if (we_i[i]) begin
                    mem_q[waddr_i[i][addr_w-1:0]] <= wdata_i[i];
                end
            end
        end
    end

endmodule

/* logic/rob_dispatch_stage.sv */
`timescale 1ns/10ps

module rob_dispatch_stage #(
    parameter int rob_depth_log2 = 4
) (
    input  logic                                clk,
    input  logic                                rst_n_i,
    input  logic                                flush_i,

    // front end
    input  logic                  [1:0]         front_valid_i,
    input  rob_pkg::front_inst_t  [1:0]         front_inst_i,
    output logic                                front_ready_o,

    // execution lanes and buffer state
    input  logic                  [1:0]         lane_ready_i,
    input  logic                  [rob_depth_log2:0] rob_free_cnt_i,

    // issue and allocation
    output rob_pkg::issue_t       [1:0]         issue_o,
    output logic                  [1:0]         issue_valid_o,
    output logic                  [1:0]         alloc_valid_o,
    output rob_pkg::rob_inst_entry_t [1:0]      alloc_entry_o
);

    import rob_pkg::*;

    localparam int cnt_w = rob_depth_log2 + 1;

    logic [rob_depth_log2-1:0] head_q;
    logic [rob_depth_log2-1:0] head_p1;
    logic                      ready_en_q;
    logic [1:0]                accept;

    ////////////////////
    // handshake
    ////////////////////

    // room for a full pair and both lanes free
    assign front_ready_o = ready_en_q && !flush_i
                        && (rob_free_cnt_i >= cnt_w'(2))
                        && (&lane_ready_i);

    assign accept        = front_valid_i & {2{front_ready_o}};
    assign issue_valid_o = accept;
    assign alloc_valid_o = accept;

    // second slot wraps inside the buffer depth
    assign head_p1 = head_q + rob_depth_log2'(1);

    ////////////////////
    // split into issue and table entry
    ////////////////////

    always_comb begin
        for (int k = 0; k < 2; k++) begin
            issue_o[k].op        = front_inst_i[k].op;
            issue_o[k].operand_a = front_inst_i[k].operand_a;
            issue_o[k].operand_b = front_inst_i[k].operand_b;
            alloc_entry_o[k].areg = front_inst_i[k].areg;
            alloc_entry_o[k].pc   = front_inst_i[k].pc;
        end
        // lane 0 is older and takes the head slot
        issue_o[0].slot = rob_idx_t'(head_q);
        issue_o[1].slot = rob_idx_t'(head_p1);
    end

    // head pointer moves by the number accepted
    always_ff @(posedge clk) begin
        if (!rst_n_i || flush_i) begin
            head_q     <= '0;
            ready_en_q <= 1'b0;
        end else begin
            head_q     <= head_q + rob_depth_log2'(accept[0])
                                 + rob_depth_log2'(accept[1]);
            ready_en_q <= 1'b1;
        end
    end

endmodule

/* logic/rob_core.sv */
`timescale 1ns/10ps

module rob_core #(
    parameter int rob_depth_log2 = 4
) (
    input  logic                                 clk,
    input  logic                                 rst_n_i,
    input  logic                                 flush_i,

    // allocation from dispatch
    input  logic                     [1:0]       alloc_valid_i,
    input  rob_pkg::rob_idx_t        [1:0]       alloc_slot_i,
    input  rob_pkg::rob_inst_entry_t [1:0]       alloc_entry_i,

    // results
    input  rob_pkg::cdb_t            [1:0]       cdb_i,

    // commit side
    input  logic                     [1:0]       commit_req_i,
    output rob_pkg::retire_t         [1:0]       head_entries_o,
    output logic                     [rob_depth_log2:0] rob_free_cnt_o
);

    import rob_pkg::*;

    localparam int depth = 1 << rob_depth_log2;
    localparam int cnt_w = rob_depth_log2 + 1;

    logic [rob_depth_log2-1:0] tail0_q, tail1_q;
    logic [cnt_w-1:0]          cnt_q;
    logic [1:0]                alloc_n, commit_n;
    rob_idx_t [1:0]            tail_idx;
    logic                      table_rst_n;

    ////////////////////
    // pointers and count
    ////////////////////

    assign alloc_n  = alloc_valid_i[0] + alloc_valid_i[1];
    assign commit_n = commit_req_i[0] + commit_req_i[1];

    always_ff @(posedge clk) begin
        if (!rst_n_i || flush_i) begin
            tail0_q <= '0;
            tail1_q <= rob_depth_log2'(1);
            cnt_q   <= '0;
        end else begin
            tail0_q <= tail0_q + rob_depth_log2'(commit_n);
            tail1_q <= tail1_q + rob_depth_log2'(commit_n);
            cnt_q   <= cnt_q + cnt_w'(alloc_n) - cnt_w'(commit_n);
        end
    end

    assign rob_free_cnt_o = cnt_w'(depth) - cnt_q;
    assign tail_idx       = {rob_idx_t'(tail1_q), rob_idx_t'(tail0_q)};

    // toggle tables restart with flush as well
    assign table_rst_n = rst_n_i & ~flush_i;

    ////////////////////
    // instruction and data tables
    ////////////////////

    rob_inst_entry_t [1:0] head_inst;
    rob_data_entry_t [1:0] head_data;
    rob_data_entry_t [1:0] cdb_wdata;
    rob_idx_t        [1:0] cdb_slot;
    logic            [1:0] cdb_we;

    always_comb begin
        for (int k = 0; k < 2; k++) begin
            cdb_we[k]         = cdb_i[k].valid;
            cdb_slot[k]       = cdb_i[k].slot;
            cdb_wdata[k].data = cdb_i[k].data;
        end
    end

    banked_regfile #(
        .entry_t    (rob_inst_entry_t),
        .depth      (depth),
        .r_ports    (2),
        .w_ports    (2),
        .need_reset (1'b0)
    ) inst_table_i (
        .clk,
        .rst_n_i,
        .raddr_i (tail_idx),
        .rdata_o (head_inst),
        .waddr_i (alloc_slot_i),
        .we_i    (alloc_valid_i),
        .wdata_i (alloc_entry_i)
    );

    banked_regfile #(
        .entry_t    (rob_data_entry_t),
        .depth      (depth),
        .r_ports    (2),
        .w_ports    (2),
        .need_reset (1'b0)
    ) data_table_i (
        .clk,
        .rst_n_i,
        .raddr_i (tail_idx),
        .rdata_o (head_data),
        .waddr_i (cdb_slot),
        .we_i    (cdb_we),
        .wdata_i (cdb_wdata)
    );

    ////////////////////
    // completion toggles
    ////////////////////

    logic [1:0] disp_tog_rd;
    // [1:0] head, [3:2] alloc slots, [5:4] bus slots
    logic [5:0] bus_tog_rd;

    // alloc snapshots the bus bit, so a fresh entry reads as not complete
    banked_regfile #(
        .entry_t    (logic),
        .depth      (depth),
        .r_ports    (2),
        .w_ports    (2),
        .need_reset (1'b1)
    ) disp_tog_table_i (
        .clk,
        .rst_n_i (table_rst_n),
        .raddr_i (tail_idx),
        .rdata_o (disp_tog_rd),
        .waddr_i (alloc_slot_i),
        .we_i    (alloc_valid_i),
        .wdata_i (bus_tog_rd[3:2])
    );

    // a result flips the bus bit
    banked_regfile #(
        .entry_t    (logic),
        .depth      (depth),
        .r_ports    (6),
        .w_ports    (2),
        .need_reset (1'b1)
    ) bus_tog_table_i (
        .clk,
        .rst_n_i (table_rst_n),
        .raddr_i ({cdb_slot, alloc_slot_i, tail_idx}),
        .rdata_o (bus_tog_rd),
        .waddr_i (cdb_slot),
        .we_i    (cdb_we),
        .wdata_i (~bus_tog_rd[5:4])
    );

    always_comb begin
        for (int k = 0; k < 2; k++) begin
            head_entries_o[k].valid = (disp_tog_rd[k] ^ bus_tog_rd[k])
                                   && (cnt_q > cnt_w'(k));
            head_entries_o[k].areg  = head_inst[k].areg;
            head_entries_o[k].data  = head_data[k].data;
            head_entries_o[k].pc    = head_inst[k].pc;
        end
    end

endmodule

/* logic/exec_unit.sv */
`timescale 1ns/10ps

module exec_unit #(
    parameter int mul_latency = 3
) (
    input  logic                      clk,
    input  logic                      rst_n_i,
    input  logic                      flush_i,

    input  rob_pkg::issue_t [1:0]     issue_i,
    input  logic            [1:0]     issue_valid_i,
    output logic            [1:0]     lane_ready_o,

    // one bus lane per execution lane
    output rob_pkg::cdb_t   [1:0]     cdb_o
);

    import rob_pkg::*;

    localparam int cnt_w = $clog2(mul_latency);

    logic     [1:0]       busy_q;
    logic     [cnt_w-1:0] cnt_q    [2];
    rob_idx_t             slot_q   [2];
    logic     [31:0]      result_q [2];
    logic     [1:0]       done;

    ////////////////////
    // lane state
    ////////////////////

    always_comb begin
        for (int k = 0; k < 2; k++) begin
            done[k]         = busy_q[k] && (cnt_q[k] == '0);
            // idle, or handing its result over this cycle
            lane_ready_o[k] = !busy_q[k] || (cnt_q[k] == '0);
            cdb_o[k].valid  = done[k] && !flush_i;
            cdb_o[k].slot   = slot_q[k];
            cdb_o[k].data   = result_q[k];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i || flush_i) begin
            busy_q <= '0;
        end else begin
            for (int k = 0; k < 2; k++) begin
                if (issue_valid_i[k]) begin
                    busy_q[k] <= 1'b1;
                end else if (done[k]) begin
                    busy_q[k] <= 1'b0;
                end
            end
        end
    end

    // countdown and result per lane
    always_ff @(posedge clk) begin
        for (int k = 0; k < 2; k++) begin
            if (issue_valid_i[k]) begin
                // alu ops finish after one cycle, mul after mul_latency
                cnt_q[k]    <= (issue_i[k].op == op_mul) ? cnt_w'(mul_latency - 1) : '0;
                slot_q[k]   <= issue_i[k].slot;
                result_q[k] <= alu_result(issue_i[k].op, issue_i[k].operand_a,
                                          issue_i[k].operand_b);
            end else if (busy_q[k] && (cnt_q[k] != '0)) begin
                cnt_q[k] <= cnt_q[k] - cnt_w'(1);
            end
        end
    end

endmodule

/* logic/commit_stage.sv */
`timescale 1ns/10ps

module commit_stage (
    input  logic                       clk,
    input  logic                       rst_n_i,
    input  logic                       flush_i,

    // buffer head
    input  rob_pkg::retire_t [1:0]     head_entries_i,
    output logic             [1:0]     commit_req_o,

    // retire port
    output rob_pkg::retire_t [1:0]     retire_o,
    output logic                       retire_valid_o,
    input  logic                       retire_ready_i,

    // architectural register read
    input  rob_pkg::areg_t             arf_raddr_i,
    output logic             [31:0]    arf_rdata_o
);

    import rob_pkg::*;

    retire_t [1:0] retire_q;
    logic    [1:0] lane_vld_q;
    logic          can_load;
    logic [31:0]   arf_q [32];

    ////////////////////
    // retire selection
    ////////////////////

    // output register empty or draining this cycle
    assign can_load = !lane_vld_q[0] || retire_ready_i;

    // completed prefix only, so lane 1 never goes without lane 0
    assign commit_req_o[0] = can_load && !flush_i && head_entries_i[0].valid;
    assign commit_req_o[1] = commit_req_o[0] && head_entries_i[1].valid;

    always_ff @(posedge clk) begin
        if (!rst_n_i || flush_i) begin
            lane_vld_q <= '0;
        end else if (can_load) begin
            lane_vld_q <= commit_req_o;
        end
    end

    always_ff @(posedge clk) begin
        if (can_load) begin
            retire_q <= head_entries_i;
        end
    end

    always_comb begin
        for (int k = 0; k < 2; k++) begin
            retire_o[k]       = retire_q[k];
            retire_o[k].valid = lane_vld_q[k];
        end
    end

    assign retire_valid_o = lane_vld_q[0];

    ////////////////////
    // architectural register file
    ////////////////////

    // lane 1 is younger and wins a same-register write
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int r = 0; r < 32; r++) begin
                arf_q[r] <= '0;
            end
        end else begin
            for (int k = 0; k < 2; k++) begin
                if (commit_req_o[k]) begin
                    arf_q[head_entries_i[k].areg] <= head_entries_i[k].data;
                end
            end
        end
    end

    assign arf_rdata_o = (arf_raddr_i == areg_t'(0)) ? 32'd0 : arf_q[arf_raddr_i];

endmodule

/* logic/rob_top.sv */
`timescale 1ns/10ps

module rob_top #(
    parameter int rob_depth_log2 = 4,
    parameter int mul_latency    = 3
) (
    input  logic                         clk,
    input  logic                         rst_n_i,
    input  logic                         flush_i,

    input  logic                 [1:0]   front_valid_i,
    input  rob_pkg::front_inst_t [1:0]   front_inst_i,
    output logic                         front_ready_o,

    output rob_pkg::retire_t     [1:0]   retire_o,
    output logic                         retire_valid_o,
    input  logic                         retire_ready_i,

    input  rob_pkg::areg_t               arf_raddr_i,
    output logic                 [31:0]  arf_rdata_o
);

    import rob_pkg::*;

    issue_t          [1:0]      issue;
    logic            [1:0]      issue_valid;
    logic            [1:0]      lane_ready;
    logic            [1:0]      alloc_valid;
    rob_inst_entry_t [1:0]      alloc_entry;
    rob_idx_t        [1:0]      alloc_slot;
    logic [rob_depth_log2:0]    rob_free_cnt;
    cdb_t            [1:0]      cdb;
    retire_t         [1:0]      head_entries;
    logic            [1:0]      commit_req;

    // the issued slot is the allocated slot
    assign alloc_slot = {issue[1].slot, issue[0].slot};

    rob_dispatch_stage #(
        .rob_depth_log2 (rob_depth_log2)
    ) dispatch_i (
        .clk,
        .rst_n_i,
        .flush_i,
        .front_valid_i,
        .front_inst_i,
        .front_ready_o,
        .lane_ready_i   (lane_ready),
        .rob_free_cnt_i (rob_free_cnt),
        .issue_o        (issue),
        .issue_valid_o  (issue_valid),
        .alloc_valid_o  (alloc_valid),
        .alloc_entry_o  (alloc_entry)
    );

    exec_unit #(
        .mul_latency (mul_latency)
    ) exec_i (
        .clk,
        .rst_n_i,
        .flush_i,
        .issue_i       (issue),
        .issue_valid_i (issue_valid),
        .lane_ready_o  (lane_ready),
        .cdb_o         (cdb)
    );

    rob_core #(
        .rob_depth_log2 (rob_depth_log2)
    ) rob_i (
        .clk,
        .rst_n_i,
        .flush_i,
        .alloc_valid_i  (alloc_valid),
        .alloc_slot_i   (alloc_slot),
        .alloc_entry_i  (alloc_entry),
        .cdb_i          (cdb),
        .commit_req_i   (commit_req),
        .head_entries_o (head_entries),
        .rob_free_cnt_o (rob_free_cnt)
    );

    commit_stage commit_i (
        .clk,
        .rst_n_i,
        .flush_i,
        .head_entries_i (head_entries),
        .commit_req_o   (commit_req),
        .retire_o,
        .retire_valid_o,
        .retire_ready_i,
        .arf_raddr_i,
        .arf_rdata_o
    );

endmodule

/* testbench/rob_tb.sv */
`timescale 1ns/10ps

module rob_tb;

    import rob_pkg::*;

    localparam int rob_depth_log2 = 4;
    localparam int mul_latency    = 3;
    localparam int depth          = 1 << rob_depth_log2;

    // test lengths, in accepted front-end transfers or in cycles
    localparam int n_single       = 40;
    localparam int n_pair         = 4;
    localparam int n_random       = 150;
    localparam int n_full_cycles  = 60;
    localparam int n_flush        = 60;
    localparam int planned_insts  = n_single
                                  + 2 * (n_pair + n_random + n_full_cycles + 2 * n_flush);
    localparam int timeout_cycles = 40 * planned_insts + 1000;

    logic              clk;
    logic              rst_n_i;
    logic              flush_i;
    logic        [1:0] front_valid_i;
    front_inst_t [1:0] front_inst_i;
    logic              front_ready_o;
    retire_t     [1:0] retire_o;
    logic              retire_valid_o;
    logic              retire_ready_i;
    areg_t             arf_raddr_i;
    logic       [31:0] arf_rdata_o;

    // reference model and stimulus state
    integer            seed;
    retire_t           model_q [$];
    logic       [31:0] arf_model [32];
    logic        [1:0] offer_vld;
    front_inst_t [1:0] offer_inst;
    logic       [31:0] next_pc;
    int                accepted_cnt;
    logic              hold_q;
    retire_t     [1:0] held_q;
    logic              last_front_ready;
    logic              after_flush;

    rob_top #(
        .rob_depth_log2 (rob_depth_log2),
        .mul_latency    (mul_latency)
    ) dut_i (
        .clk,
        .rst_n_i,
        .flush_i,
        .front_valid_i,
        .front_inst_i,
        .front_ready_o,
        .retire_o,
        .retire_valid_o,
        .retire_ready_i,
        .arf_raddr_i,
        .arf_rdata_o
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    ////////////////////
    // model and checks
    ////////////////////

    function automatic logic [31:0] expected_result(
        input op_e         op,
        input logic [31:0] a,
        input logic [31:0] b
    );
        logic [63:0] product;
        product = {32'd0, a} * {32'd0, b};
        case (op)
            op_add:  return a + b;
            op_sub:  return a + ~b + 32'd1;
            op_xor:  return a ^ b;
            default: return product[31:0];
        endcase
    endfunction

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic check_retire(input retire_t exp, input int lane);
        if (retire_o[lane] !== exp) begin
            stop_run($sformatf("ERROR %0t retire_o[%0d] expected %h actual %h",
                               $time, lane, exp, retire_o[lane]));
        end
    endtask

    task automatic check_arf(input areg_t addr, input logic [31:0] exp);
        @(negedge clk);
        front_valid_i = '0;
        arf_raddr_i   = addr;
        #1;
        if (arf_rdata_o !== exp) begin
            stop_run($sformatf("ERROR %0t arf_rdata_o[%0d] expected %h actual %h",
                               $time, addr, exp, arf_rdata_o));
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            stop_run($sformatf("ERROR %0t %s expected %b actual %b",
                               $time, name, exp, act));
        end
    endtask

    task automatic check_bus_cycle(input string name, input int exp, input int act);
        if (act !== exp) begin
            stop_run($sformatf("ERROR %0t %s expected cycle %0d actual cycle %0d",
                               $time, name, exp, act));
        end
    endtask

    ////////////////////
    // stimulus
    ////////////////////

    function automatic logic random_ready();
        logic [31:0] r;
        r = $random(seed);
        return r[1:0] != 2'b00;
    endfunction

    // lane 1 only ever together with lane 0
    function automatic logic [1:0] random_lanes();
        logic [31:0] r;
        r = $random(seed);
        return r[0] ? 2'b11 : 2'b01;
    endfunction

    task automatic make_offer(input logic [1:0] lanes);
        logic [31:0] r;
        for (int k = 0; k < 2; k++) begin
            r = $random(seed);
            offer_inst[k].op        = op_e'(r[1:0]);
            offer_inst[k].areg      = areg_t'(r[6:2]);
            offer_inst[k].operand_a = $random(seed);
            offer_inst[k].operand_b = $random(seed);
            offer_inst[k].pc        = next_pc;
            next_pc = next_pc + 32'd4;
        end
        offer_vld = lanes;
    endtask

    // drive on the falling edge and sample 1 ns later
    task automatic run_cycle(input logic ready, input logic flush);
        retire_t exp;
        @(negedge clk);
        front_valid_i  = offer_vld;
        front_inst_i   = offer_inst;
        retire_ready_i = ready;
        flush_i        = flush;
        #1;
        // a flush leaves the front end and retire port idle for a cycle
        if (after_flush) begin
            check_flag("front_ready_o", 1'b0, front_ready_o);
            check_flag("retire_valid_o", 1'b0, retire_valid_o);
        end
        if (hold_q) begin
            check_retire(held_q[0], 0);
            check_retire(held_q[1], 1);
        end
        // held entries at a flush already wrote the register file
        if (retire_valid_o && (ready || flush)) begin
            for (int k = 0; k < 2; k++) begin
                if (retire_o[k].valid) begin
                    if (model_q.size() == 0) begin
                        stop_run("an instruction retired that was never accepted or was flushed");
                    end
                    exp = model_q.pop_front();
                    check_retire(exp, k);
                    arf_model[exp.areg] = exp.data;
                end
            end
        end
        if (flush) begin
            model_q.delete();
        end else if (front_ready_o && (offer_vld != 2'b00)) begin
            for (int k = 0; k < 2; k++) begin
                if (offer_vld[k]) begin
                    exp.valid = 1'b1;
                    exp.areg  = offer_inst[k].areg;
                    exp.data  = expected_result(offer_inst[k].op, offer_inst[k].operand_a,
                                                offer_inst[k].operand_b);
                    exp.pc    = offer_inst[k].pc;
                    model_q.push_back(exp);
                end
            end
            offer_vld    = 2'b00;
            accepted_cnt = accepted_cnt + 1;
        end
        hold_q           = retire_valid_o && !ready && !flush;
        held_q           = retire_o;
        last_front_ready = front_ready_o;
        after_flush      = flush;
    endtask

    task automatic drain();
        while ((offer_vld != 2'b00) || (model_q.size() != 0)) begin
            run_cycle(1'b1, 1'b0);
        end
    endtask

    ////////////////////
    // test sequence
    ////////////////////

    initial begin
        int          add_at;
        int          mul_at;
        int          flush_at;
        logic [31:0] r;

        seed             = 32'h1d991fa3;
        rst_n_i          = 1'b0;
        flush_i          = 1'b0;
        front_valid_i    = '0;
        front_inst_i     = '0;
        retire_ready_i   = 1'b0;
        arf_raddr_i      = '0;
        offer_vld        = '0;
        offer_inst       = '0;
        next_pc          = 32'h0000_1000;
        hold_q           = 1'b0;
        held_q           = '0;
        last_front_ready = 1'b0;
        after_flush      = 1'b0;
        for (int a = 0; a < 32; a++) begin
            arf_model[a] = '0;
        end
        repeat (4) @(negedge clk);
        rst_n_i = 1'b1;

        // first cycle out of reset
        #1;
        check_flag("front_ready_o", 1'b0, front_ready_o);
        check_flag("retire_valid_o", 1'b0, retire_valid_o);

        // single lane, mixed opcodes
        accepted_cnt = 0;
        while (accepted_cnt < n_single) begin
            if (offer_vld == 2'b00) make_offer(2'b01);
            run_cycle(1'b1, 1'b0);
        end
        drain();

        // the younger add on lane 1 overtakes the mul on the bus
        for (int p = 0; p < n_pair; p++) begin
            make_offer(2'b11);
            offer_inst[0].op = op_mul;
            offer_inst[1].op = op_add;
            while (offer_vld != 2'b00) run_cycle(1'b1, 1'b0);
            add_at = 0;
            mul_at = 0;
            for (int c = 1; c <= mul_latency + 2; c++) begin
                run_cycle(1'b1, 1'b0);
                if (dut_i.cdb[1].valid && (add_at == 0)) add_at = c;
                if (dut_i.cdb[0].valid && (mul_at == 0)) mul_at = c;
            end
            check_bus_cycle("cdb[1].valid", 1, add_at);
            check_bus_cycle("cdb[0].valid", mul_latency, mul_at);
            drain();
        end

        // dual-lane traffic with random retire stalls
        accepted_cnt = 0;
        while (accepted_cnt < n_random) begin
            if (offer_vld == 2'b00) make_offer(random_lanes());
            run_cycle(random_ready(), 1'b0);
        end
        drain();

        // retire held off until the buffer fills
        for (int c = 0; c < n_full_cycles; c++) begin
            if (offer_vld == 2'b00) make_offer(2'b11);
            run_cycle(1'b0, 1'b0);
        end
        if (last_front_ready) begin
            stop_run("front_ready_o stayed high while retire_ready_i was held low");
        end
        if (model_q.size() < depth - 1) begin
            stop_run("the buffer did not fill while retire_ready_i was held low");
        end
        drain();

        // flush in the middle of traffic
        r        = $random(seed);
        flush_at = 10 + r[4:0];
        for (int c = 0; c <= flush_at; c++) begin
            if (offer_vld == 2'b00) make_offer(random_lanes());
            if (c == flush_at) begin
                run_cycle(1'b0, 1'b1);
            end else begin
                run_cycle(random_ready(), 1'b0);
            end
        end
        accepted_cnt = 0;
        while (accepted_cnt < n_flush) begin
            if (offer_vld == 2'b00) make_offer(random_lanes());
            run_cycle(random_ready(), 1'b0);
        end
        drain();

        // architectural state after the drain
        for (int a = 0; a < 32; a++) begin
            check_arf(areg_t'(a), (a == 0) ? 32'd0 : arf_model[a]);
        end

        $display("sim passed");
        $finish;
    end

    // watchdog
    initial begin
        repeat (timeout_cycles) @(posedge clk);
        stop_run("watchdog expired before the tests finished");
    end

endmodule

/* sources.f */
logic/rob_pkg.sv
logic/banked_regfile.sv
logic/rob_dispatch_stage.sv
logic/rob_core.sv
logic/exec_unit.sv
logic/commit_stage.sv
logic/rob_top.sv
testbench/rob_tb.sv
